// ==== prf.f ====
+incdir+rtl
rtl/prf_reg_pkg.sv
rtl/prf_wb_pkg.sv
rtl/prf_bank_ifs.sv
rtl/req_queue.sv
rtl/read_arbiter2.sv
rtl/write_arbiter.sv
rtl/prf_bank.sv
rtl/prf.sv
testbench/prf_props.sv
testbench/prf_tb.sv

// ==== rtl/prf.sv ====
//--------------------------------------------------------------------------
// banked physical register file, top level
// responses have variable latency and come back in order per requestor
// outputs have no back-pressure, only the input readies stall requestors
//--------------------------------------------------------------------------
`include "prf_cfg.svh"

module prf
    import prf_reg_pkg::*;
    import prf_wb_pkg::*;
(
    input  logic                             CLK,
    input  logic                             nRST,

    // read requests
    input  rr_vec_t                          read_req_valid,
    input  pr_t       [`PRF_RR_COUNT-1:0]    read_req_pr,
    output rr_vec_t                          read_req_ready,

    // read responses
    output rr_vec_t                          read_resp_valid,
    output reg_data_t [`PRF_RR_COUNT-1:0]    read_resp_data,

    // writebacks
    input  wr_vec_t                          wb_valid,
    input  wr_vec_t                          wb_send_complete,
    input  reg_data_t [`PRF_WR_COUNT-1:0]    wb_data,
    input  pr_t       [`PRF_WR_COUNT-1:0]    wb_pr,
    input  rob_idx_t  [`PRF_WR_COUNT-1:0]    wb_rob_index,
    output wr_vec_t                          wb_ready,

    // completions, one bus per bank
    output logic      [`PRF_BANK_COUNT-1:0]  complete_valid,
    output rob_idx_t  [`PRF_BANK_COUNT-1:0]  complete_rob_index
);
    localparam int RR     = `PRF_RR_COUNT;
    localparam int WR     = `PRF_WR_COUNT;
    localparam int BANKS  = `PRF_BANK_COUNT;
    localparam int BANK_W = $bits(bank_idx_t);
    localparam int PR_W   = $bits(pr_t);

    // bank travels next to the request through the write queue
    typedef struct packed {
        bank_idx_t  bank;
        write_req_t req;
    } wr_entry_t;

    pr_t        [RR-1:0]    rd_head;
    upper_pr_t  [RR-1:0]    rd_head_row;
    rr_vec_t                rd_head_valid;
    rr_vec_t                rd_deq;

    wr_entry_t  [WR-1:0]    wr_enq;
    wr_entry_t  [WR-1:0]    wr_head;
    write_req_t [WR-1:0]    wr_head_req;
    wr_vec_t                wr_head_valid;
    wr_vec_t                wr_deq;

    rr_vec_t    [BANKS-1:0] rd_bank_valid;
    rr_vec_t    [BANKS-1:0] rd_grant0;
    rr_vec_t    [BANKS-1:0] rd_grant1;
    reg_data_t  [BANKS-1:0] rd_data0;
    reg_data_t  [BANKS-1:0] rd_data1;
    wr_vec_t    [BANKS-1:0] wr_bank_valid;
    wr_vec_t    [BANKS-1:0] wr_grant;

    // ----------------------------------------------------------------------
    // input queues

    // the full register number keeps both row and bank
    for (genvar i = 0; i < RR; i++) begin : g_rd_q
        req_queue #(.WIDTH(PR_W)) u_q (
            .CLK       (CLK),
            .nRST      (nRST),
            .enq_valid (read_req_valid[i]),
            .enq_data  (read_req_pr[i]),
            .enq_ready (read_req_ready[i]),
            .deq_valid (rd_head_valid[i]),
            .deq_data  (rd_head[i]),
            .deq_ready (rd_deq[i])
        );
        assign rd_head_row[i] = rd_head[i][PR_W-1:BANK_W];
    end

    always_comb begin
        for (int i = 0; i < WR; i++) begin
            wr_enq[i].bank              = wb_pr[i][BANK_W-1:0];
            wr_enq[i].req.perform_write = (wb_pr[i] != '0);
            wr_enq[i].req.send_complete = wb_send_complete[i];
            wr_enq[i].req.data          = wb_data[i];
            wr_enq[i].req.row           = wb_pr[i][PR_W-1:BANK_W];
            wr_enq[i].req.rob_index     = wb_rob_index[i];
            wr_head_req[i]              = wr_head[i].req;
        end
    end

    for (genvar i = 0; i < WR; i++) begin : g_wr_q
        req_queue #(.WIDTH($bits(wr_entry_t))) u_q (
            .CLK       (CLK),
            .nRST      (nRST),
            .enq_valid (wb_valid[i]),
            .enq_data  (wr_enq[i]),
            .enq_ready (wb_ready[i]),
            .deq_valid (wr_head_valid[i]),
            .deq_data  (wr_head[i]),
            .deq_ready (wr_deq[i])
        );
    end

    // ----------------------------------------------------------------------
    // steer queue heads to their banks

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            for (int i = 0; i < RR; i++) begin
                rd_bank_valid[b][i] = rd_head_valid[i]
                                      && rd_head[i][BANK_W-1:0] == bank_idx_t'(b);
            end
            for (int i = 0; i < WR; i++) begin
                wr_bank_valid[b][i] = wr_head_valid[i] && wr_head[i].bank == bank_idx_t'(b);
            end
        end
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        bank_read_if  rd_if ();
        bank_write_if wr_if ();

        assign rd_if.req_valid = rd_bank_valid[b];
        assign rd_if.req_row   = rd_head_row;
        assign rd_grant0[b]    = rd_if.grant0;
        assign rd_grant1[b]    = rd_if.grant1;
        assign rd_data0[b]     = rd_if.data0;
        assign rd_data1[b]     = rd_if.data1;

        assign wr_if.req_valid = wr_bank_valid[b];
        assign wr_if.req       = wr_head_req;
        assign wr_grant[b]     = wr_if.grant;

        prf_bank u_bank (
            .CLK                (CLK),
            .nRST               (nRST),
            .rd                 (rd_if.bank),
            .wr                 (wr_if.bank),
            .complete_valid     (complete_valid[b]),
            .complete_rob_index (complete_rob_index[b])
        );
    end

    // ----------------------------------------------------------------------
    // grants pop the queues and return read data

    always_comb begin
        rd_deq         = '0;
        wr_deq         = '0;
        read_resp_data = '0;
        for (int b = 0; b < BANKS; b++) begin
            rd_deq |= rd_grant0[b] | rd_grant1[b];
            wr_deq |= wr_grant[b];
            for (int i = 0; i < RR; i++) begin
                if (rd_grant0[b][i]) read_resp_data[i] |= rd_data0[b];
                if (rd_grant1[b][i]) read_resp_data[i] |= rd_data1[b];
            end
        end
    end

    assign read_resp_valid = rd_deq;

endmodule

// ==== rtl/prf_bank.sv ====
//--------------------------------------------------------------------------
// one register bank with two combinational read ports and one write port
// a write lands on the edge ending its grant cycle, a completion leaves
// one cycle after the grant
//--------------------------------------------------------------------------
`include "prf_cfg.svh"

module prf_bank
    import prf_reg_pkg::*;
    import prf_wb_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    bank_read_if.bank  rd,
    bank_write_if.bank wr,
    output logic       complete_valid,
    output rob_idx_t   complete_rob_index
);
    localparam int ROWS = `PRF_PR_COUNT / `PRF_BANK_COUNT;

    reg_data_t  mem [ROWS];
    upper_pr_t  row0;
    upper_pr_t  row1;
    write_req_t sel_wr;
    logic       wr_any;

    read_arbiter2 u_rd_arb (
        .CLK    (CLK),
        .nRST   (nRST),
        .req    (rd.req_valid),
        .grant0 (rd.grant0),
        .grant1 (rd.grant1)
    );

    write_arbiter u_wr_arb (
        .CLK   (CLK),
        .nRST  (nRST),
        .req   (wr.req_valid),
        .grant (wr.grant)
    );

    // ----------------------------------------------------------------------
    // one-hot grant muxes

    always_comb begin
        row0   = '0;
        row1   = '0;
        sel_wr = '0;
        for (int i = 0; i < `PRF_RR_COUNT; i++) begin
            if (rd.grant0[i]) row0 |= rd.req_row[i];
            if (rd.grant1[i]) row1 |= rd.req_row[i];
        end
        for (int i = 0; i < `PRF_WR_COUNT; i++) begin
            if (wr.grant[i]) sel_wr = sel_wr | wr.req[i];
        end
    end

    assign wr_any = |wr.grant;

    // ----------------------------------------------------------------------
    // storage

    assign rd.data0 = mem[row0];
    assign rd.data1 = mem[row1];

    // register 0 arrives with perform_write clear
    always_ff @(posedge CLK) begin
        if (wr_any && sel_wr.perform_write) mem[sel_wr.row] <= sel_wr.data;
    end

    // ----------------------------------------------------------------------
    // completion bus

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            complete_valid <= 1'b0;
        end else begin
            complete_valid <= wr_any & sel_wr.send_complete;
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_any) complete_rob_index <= sel_wr.rob_index;
    end

endmodule

// ==== rtl/prf_bank_ifs.sv ====
//--------------------------------------------------------------------------
// per-bank read and write traffic between the top level and one bank
// grants are one-hot or zero, read data is valid in the grant cycle
//--------------------------------------------------------------------------
`include "prf_cfg.svh"

interface bank_read_if import prf_reg_pkg::*; ();

    // queue heads already masked to this bank
    rr_vec_t                         req_valid;
    upper_pr_t [`PRF_RR_COUNT-1:0]   req_row;

    // one grant per storage read port
    rr_vec_t                         grant0;
    rr_vec_t                         grant1;
    reg_data_t                       data0;
    reg_data_t                       data1;

    modport bank (
        input  req_valid,
        input  req_row,
        output grant0,
        output grant1,
        output data0,
        output data1
    );

    modport client (
        output req_valid,
        output req_row,
        input  grant0,
        input  grant1,
        input  data0,
        input  data1
    );

endinterface

interface bank_write_if import prf_wb_pkg::*; ();

    wr_vec_t                          req_valid;
    write_req_t [`PRF_WR_COUNT-1:0]   req;
    wr_vec_t                          grant;

    modport bank (
        input  req_valid,
        input  req,
        output grant
    );

    modport client (
        output req_valid,
        output req,
        input  grant
    );

endinterface

// ==== rtl/prf_cfg.svh ====
//--------------------------------------------------------------------------
// sizing of the banked register file
// bank count is a power of two and divides the register count
// requestor counts must be two or more
//--------------------------------------------------------------------------
`ifndef PRF_CFG_SVH
`define PRF_CFG_SVH

// register file geometry
`define PRF_PR_COUNT     64
`define PRF_BANK_COUNT   4

// requestors and their input queues
`define PRF_RR_COUNT     4
`define PRF_WR_COUNT     3
`define PRF_QUEUE_DEPTH  2

// ROB and datapath
`define PRF_ROB_ENTRIES  32
`define PRF_DATA_WIDTH   32

`endif

// ==== rtl/prf_reg_pkg.sv ====
//--------------------------------------------------------------------------
// register addressing and data types
// the bank comes from the low bits of a register number, the row from
// the bits above it
//--------------------------------------------------------------------------
`include "prf_cfg.svh"

package prf_reg_pkg;

    // full physical register number
    typedef logic [$clog2(`PRF_PR_COUNT)-1:0] pr_t;

    // row inside one bank
    typedef logic [$clog2(`PRF_PR_COUNT/`PRF_BANK_COUNT)-1:0] upper_pr_t;

    typedef logic [$clog2(`PRF_BANK_COUNT)-1:0] bank_idx_t;

    typedef logic [`PRF_DATA_WIDTH-1:0] reg_data_t;

    // one bit per read requestor
    typedef logic [`PRF_RR_COUNT-1:0] rr_vec_t;

endpackage

// ==== rtl/prf_wb_pkg.sv ====
//--------------------------------------------------------------------------
// writeback and completion types
// a write request carries the row only, the bank is routed beside it
//--------------------------------------------------------------------------
`include "prf_cfg.svh"

package prf_wb_pkg;

    import prf_reg_pkg::*;

    typedef logic [$clog2(`PRF_ROB_ENTRIES)-1:0] rob_idx_t;

    // one bit per write requestor
    typedef logic [`PRF_WR_COUNT-1:0] wr_vec_t;

    typedef struct packed {
        logic      perform_write;
        logic      send_complete;
        reg_data_t data;
        upper_pr_t row;
        rob_idx_t  rob_index;
    } write_req_t;

endpackage

// ==== rtl/read_arbiter2.sv ====
//--------------------------------------------------------------------------
// round-robin read arbiter with two grants per cycle
// grant0 takes the first requestor at or after the pointer, grant1 the
// next one, the pointer then moves past the last grant
//--------------------------------------------------------------------------
`include "prf_cfg.svh"

module read_arbiter2
    import prf_reg_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,
    input  rr_vec_t req,
    output rr_vec_t grant0,
    output rr_vec_t grant1
);
    localparam int N     = `PRF_RR_COUNT;
    localparam int PTR_W = $clog2(N);

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] last;

    // scan from the pointer, wrapping around
    always_comb begin
        int idx;
        grant0 = '0;
        grant1 = '0;
        last   = ptr;
        for (int i = 0; i < N; i++) begin
            idx = (int'(ptr) + i) % N;
            if (req[idx]) begin
                if (grant0 == '0) begin
                    grant0[idx] = 1'b1;
                    last        = PTR_W'(idx);
                end else if (grant1 == '0) begin
                    grant1[idx] = 1'b1;
                    last        = PTR_W'(idx);
                end
            end
        end
    end

    // pointer holds when nothing is granted
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ptr <= '0;
        end else if (|req) begin
            ptr <= (last == PTR_W'(N - 1)) ? '0 : last + 1'b1;
        end
    end

endmodule

// ==== rtl/req_queue.sv ====
//--------------------------------------------------------------------------
// input queue for one requestor
// enq_ready never looks at enq_valid, a full queue still takes a new
// entry in the cycle its head leaves
//--------------------------------------------------------------------------
`include "prf_cfg.svh"

module req_queue #(
    parameter int WIDTH = 8
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             enq_valid,
    input  logic [WIDTH-1:0] enq_data,
    output logic             enq_ready,
    output logic             deq_valid,
    output logic [WIDTH-1:0] deq_data,
    input  logic             deq_ready
);
    localparam int DEPTH = `PRF_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_enq;
    logic             do_deq;

    function automatic logic [PTR_W-1:0] bump(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign deq_valid = (count != '0);
    assign deq_data  = mem[rd_ptr];
    assign enq_ready = (count != CNT_W'(DEPTH)) || deq_ready;
    assign do_enq    = enq_valid & enq_ready;
    assign do_deq    = deq_valid & deq_ready;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) wr_ptr <= bump(wr_ptr);
            if (do_deq) rd_ptr <= bump(rd_ptr);
            count <= count + CNT_W'(do_enq) - CNT_W'(do_deq);
        end
    end

    always_ff @(posedge CLK) begin
        if (do_enq) mem[wr_ptr] <= enq_data;
    end

endmodule

// ==== rtl/write_arbiter.sv ====
//--------------------------------------------------------------------------
// round-robin write arbiter, one grant per cycle
//--------------------------------------------------------------------------
`include "prf_cfg.svh"

module write_arbiter
    import prf_wb_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,
    input  wr_vec_t req,
    output wr_vec_t grant
);
    localparam int N     = `PRF_WR_COUNT;
    localparam int PTR_W = $clog2(N);

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] pick;

    always_comb begin
        int idx;
        grant = '0;
        pick  = ptr;
        for (int i = 0; i < N; i++) begin
            idx = (int'(ptr) + i) % N;
            if (req[idx] && grant == '0) begin
                grant[idx] = 1'b1;
                pick       = PTR_W'(idx);
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ptr <= '0;
        end else if (|req) begin
            ptr <= (pick == PTR_W'(N - 1)) ? '0 : pick + 1'b1;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the prf testbench with Verilator.
# Exits non-zero when the build fails, the run fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f prf.f --top-module prf_tb \
    -Mdir obj_dir -o prf_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/prf_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// ==== testbench/prf_props.sv ====
//--------------------------------------------------------------------------
// output checks for prf, bound into every prf instance
// the pending count per reader never exceeds the queue depth plus one
//--------------------------------------------------------------------------
`include "prf_cfg.svh"

module prf_props
    import prf_reg_pkg::*;
(
    input logic                        CLK,
    input logic                        nRST,
    input rr_vec_t                     read_req_valid,
    input rr_vec_t                     read_req_ready,
    input rr_vec_t                     read_resp_valid,
    input pr_t [`PRF_RR_COUNT-1:0]     rd_head,
    input logic [`PRF_BANK_COUNT-1:0]  complete_valid
);
    localparam int BANK_W = $bits(bank_idx_t);

    // accepted reads still waiting for their response
    logic [`PRF_RR_COUNT-1:0][2:0] pending;
    rr_vec_t                       has_pending;
    logic                          port_over;

    // responses served by one bank, found through the bank of each head
    always_comb begin
        int served;
        port_over = 1'b0;
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            has_pending[r] = (pending[r] != 3'd0);
        end
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            served = 0;
            for (int r = 0; r < `PRF_RR_COUNT; r++) begin
                if (read_resp_valid[r] && rd_head[r][BANK_W-1:0] == bank_idx_t'(b)) begin
                    served++;
                end
            end
            if (served > 2) port_over = 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pending <= '0;
        end else begin
            for (int r = 0; r < `PRF_RR_COUNT; r++) begin
                pending[r] <= pending[r] + 3'(read_req_valid[r] & read_req_ready[r])
                              - 3'(read_resp_valid[r]);
            end
        end
    end

    a_known: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown({read_resp_valid, complete_valid}))
        else $error("response or completion valid is unknown");

    a_no_orphan: assert property (@(posedge CLK) disable iff (!nRST)
        (read_resp_valid & ~has_pending) == '0)
        else $error("read response without an outstanding request");

    // two read ports per bank
    a_port_limit: assert property (@(posedge CLK) disable iff (!nRST)
        !port_over)
        else $error("more read responses from one bank than its read ports");

endmodule

bind prf prf_props props0 (
    .CLK             (CLK),
    .nRST            (nRST),
    .read_req_valid  (read_req_valid),
    .read_req_ready  (read_req_ready),
    .read_resp_valid (read_resp_valid),
    .rd_head         (rd_head),
    .complete_valid  (complete_valid)
);

// ==== testbench/prf_tb.sv ====
//--------------------------------------------------------------------------
// table-driven testbench for the banked register file
// entries with the same group number are issued together, a group ends
// when every read has returned and every completion has been seen
//--------------------------------------------------------------------------
`include "prf_cfg.svh"

module prf_tb
    import prf_reg_pkg::*;
    import prf_wb_pkg::*;
();
    localparam int RR    = `PRF_RR_COUNT;
    localparam int WR    = `PRF_WR_COUNT;
    localparam int BANKS = `PRF_BANK_COUNT;
    localparam int NUM   = 23;
    localparam int LIMIT_CYCLES = NUM * 20 + 20;

    typedef struct packed {
        logic [3:0] grp;
        logic       is_wr;
        logic [1:0] who;
        pr_t        pr;
        logic       rnd;
        reg_data_t  data;
        rob_idx_t   rob;
        logic       cmpl;
    } entry_t;

    logic                    CLK;
    logic                    nRST;
    rr_vec_t                 read_req_valid;
    pr_t       [RR-1:0]      read_req_pr;
    rr_vec_t                 read_req_ready;
    rr_vec_t                 read_resp_valid;
    reg_data_t [RR-1:0]      read_resp_data;
    wr_vec_t                 wb_valid;
    wr_vec_t                 wb_send_complete;
    reg_data_t [WR-1:0]      wb_data;
    pr_t       [WR-1:0]      wb_pr;
    rob_idx_t  [WR-1:0]      wb_rob_index;
    wr_vec_t                 wb_ready;
    logic      [BANKS-1:0]   complete_valid;
    rob_idx_t  [BANKS-1:0]   complete_rob_index;

    // grp wr who pr rnd data rob cmpl
    entry_t tbl [NUM] = '{
        '{4'd0, 1'b1, 2'd0, 6'd5,  1'b1, 32'h0,        5'd1,  1'b1},
        '{4'd1, 1'b0, 2'd2, 6'd5,  1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd2, 1'b1, 2'd1, 6'd10, 1'b1, 32'h0,        5'd2,  1'b0},
        '{4'd3, 1'b0, 2'd0, 6'd10, 1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd3, 1'b0, 2'd3, 6'd5,  1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd4, 1'b1, 2'd2, 6'd0,  1'b0, 32'hdeadbeef, 5'd3,  1'b1},
        '{4'd5, 1'b1, 2'd0, 6'd3,  1'b1, 32'h0,        5'd4,  1'b1},
        '{4'd5, 1'b1, 2'd1, 6'd7,  1'b1, 32'h0,        5'd5,  1'b1},
        '{4'd5, 1'b1, 2'd2, 6'd11, 1'b1, 32'h0,        5'd6,  1'b1},
        '{4'd5, 1'b1, 2'd0, 6'd15, 1'b1, 32'h0,        5'd7,  1'b1},
        '{4'd6, 1'b0, 2'd0, 6'd3,  1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd6, 1'b0, 2'd1, 6'd7,  1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd6, 1'b0, 2'd2, 6'd11, 1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd6, 1'b0, 2'd3, 6'd15, 1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd6, 1'b0, 2'd0, 6'd15, 1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd6, 1'b0, 2'd1, 6'd11, 1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd7, 1'b1, 2'd0, 6'd20, 1'b1, 32'h0,        5'd8,  1'b1},
        '{4'd7, 1'b1, 2'd1, 6'd21, 1'b1, 32'h0,        5'd9,  1'b1},
        '{4'd7, 1'b1, 2'd2, 6'd22, 1'b1, 32'h0,        5'd10, 1'b1},
        '{4'd8, 1'b0, 2'd0, 6'd20, 1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd8, 1'b0, 2'd1, 6'd21, 1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd8, 1'b0, 2'd2, 6'd22, 1'b0, 32'h0,        5'd0,  1'b0},
        '{4'd8, 1'b0, 2'd3, 6'd10, 1'b0, 32'h0,        5'd0,  1'b0}
    };

    reg_data_t   model [`PRF_PR_COUNT];
    reg_data_t   exp_val [NUM];
    bit          issued [NUM];
    int          exp_rd [RR][$];
    int          exp_cmpl [BANKS][$];
    int          n_cmpl_exp;
    int          n_cmpl_seen;
    logic [15:0] lfsr_state;

    prf dut0 (.*);

    always #50 CLK = ~CLK;

    // ----------------------------------------------------------------------
    // helpers

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 16'hB400;
        return b;
    endfunction

    function automatic string entry_name(int i);
        return $sformatf("e%0d_%s%0d_pr%0d", i, tbl[i].is_wr ? "wr" : "rd",
                         tbl[i].who, tbl[i].pr);
    endfunction

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_data(string name, reg_data_t exp, reg_data_t act);
        if (act !== exp) fail_now($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_rob(string name, rob_idx_t exp, rob_idx_t act);
        if (act !== exp) fail_now($sformatf("FAILED %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) fail_now($sformatf("FAILED %s expected %b actual %b", name, exp, act));
    endtask

    function automatic int next_entry(int lo, int hi, logic wr, int who);
        for (int i = lo; i < hi; i++) begin
            if (!issued[i] && tbl[i].is_wr == wr && int'(tbl[i].who) == who) return i;
        end
        return -1;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int r = 0; r < RR; r++) n += exp_rd[r].size();
        for (int b = 0; b < BANKS; b++) n += exp_cmpl[b].size();
        return n;
    endfunction

    // predictions are made when the handshake is seen
    task automatic accept(int i);
        issued[i] = 1'b1;
        if (!tbl[i].is_wr) begin
            exp_val[i] = model[tbl[i].pr];
            exp_rd[tbl[i].who].push_back(i);
        end else begin
            if (tbl[i].pr != '0) model[tbl[i].pr] = tbl[i].data;
            if (tbl[i].cmpl) begin
                exp_cmpl[tbl[i].pr[1:0]].push_back(i);
                n_cmpl_exp++;
            end
        end
    endtask

    task automatic run_group(int lo, int hi);
        int left;
        int cur_rd [RR];
        int cur_wr [WR];
        left = hi - lo;
        while (left > 0) begin
            @(posedge CLK);
            for (int r = 0; r < RR; r++) begin
                cur_rd[r] = next_entry(lo, hi, 1'b0, r);
                read_req_valid[r] <= (cur_rd[r] >= 0);
                if (cur_rd[r] >= 0) read_req_pr[r] <= tbl[cur_rd[r]].pr;
            end
            for (int w = 0; w < WR; w++) begin
                cur_wr[w] = next_entry(lo, hi, 1'b1, w);
                wb_valid[w] <= (cur_wr[w] >= 0);
                if (cur_wr[w] >= 0) begin
                    wb_pr[w]            <= tbl[cur_wr[w]].pr;
                    wb_data[w]          <= tbl[cur_wr[w]].data;
                    wb_rob_index[w]     <= tbl[cur_wr[w]].rob;
                    wb_send_complete[w] <= tbl[cur_wr[w]].cmpl;
                end
            end
            @(negedge CLK);
            for (int r = 0; r < RR; r++) begin
                if (cur_rd[r] >= 0 && read_req_ready[r]) begin
                    accept(cur_rd[r]);
                    left--;
                end
            end
            for (int w = 0; w < WR; w++) begin
                if (cur_wr[w] >= 0 && wb_ready[w]) begin
                    accept(cur_wr[w]);
                    left--;
                end
            end
        end
        @(posedge CLK);
        read_req_valid <= '0;
        wb_valid       <= '0;
        while (outstanding() != 0) @(posedge CLK);
    endtask

    // ----------------------------------------------------------------------
    // response monitors

    always @(negedge CLK) begin : watch_reads
        int idx;
        if (nRST) begin
            for (int r = 0; r < RR; r++) begin
                if (read_resp_valid[r]) begin
                    if (exp_rd[r].size() == 0) begin
                        fail_now($sformatf("reader %0d got a response it never asked for", r));
                    end else begin
                        idx = exp_rd[r].pop_front();
                        check_data(entry_name(idx), exp_val[idx], read_resp_data[r]);
                    end
                end
            end
        end
    end

    // completions within one bank may come in any writer order
    always @(negedge CLK) begin : watch_completions
        int hit;
        int idx;
        if (nRST) begin
            for (int b = 0; b < BANKS; b++) begin
                if (complete_valid[b]) begin
                    n_cmpl_seen++;
                    if (exp_cmpl[b].size() != 0) begin
                        hit = 0;
                        for (int k = 0; k < exp_cmpl[b].size(); k++) begin
                            if (tbl[exp_cmpl[b][k]].rob == complete_rob_index[b]) hit = k;
                        end
                        idx = exp_cmpl[b][hit];
                        check_rob(entry_name(idx), tbl[idx].rob, complete_rob_index[b]);
                        exp_cmpl[b].delete(hit);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(LIMIT_CYCLES * 100);
        fail_now("timeout, the DUT stopped answering before the table was done");
    end

    // ----------------------------------------------------------------------
    // main sequence

    initial begin : main
        int lo;
        int hi;
        CLK              = 1'b0;
        nRST             = 1'b0;
        read_req_valid   = '0;
        read_req_pr      = '0;
        wb_valid         = '0;
        wb_send_complete = '0;
        wb_data          = '0;
        wb_pr            = '0;
        wb_rob_index     = '0;
        n_cmpl_exp       = 0;
        n_cmpl_seen      = 0;
        lfsr_state       = 16'd5595;
        for (int i = 0; i < NUM; i++) begin
            issued[i] = 1'b0;
            if (tbl[i].rnd) begin
                for (int k = 0; k < 32; k++) tbl[i].data = {tbl[i].data[30:0], lfsr_bit()};
            end
        end

        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        for (int r = 0; r < RR; r++) begin
            check_bit($sformatf("reset_ready_r%0d", r), 1'b1, read_req_ready[r]);
            check_bit($sformatf("reset_resp_r%0d", r), 1'b0, read_resp_valid[r]);
        end
        for (int w = 0; w < WR; w++) begin
            check_bit($sformatf("reset_ready_w%0d", w), 1'b1, wb_ready[w]);
        end
        for (int b = 0; b < BANKS; b++) begin
            check_bit($sformatf("reset_complete_b%0d", b), 1'b0, complete_valid[b]);
        end

        lo = 0;
        while (lo < NUM) begin
            hi = lo;
            while (hi < NUM && tbl[hi].grp == tbl[lo].grp) hi++;
            run_group(lo, hi);
            lo = hi;
        end

        // quiet cycles so a late completion still lands in the count
        repeat (4) @(posedge CLK);
        if (n_cmpl_seen == n_cmpl_exp) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_now($sformatf("FAILED completion_count expected %0d actual %0d",
                               n_cmpl_exp, n_cmpl_seen));
        end
    end

endmodule
